// ==== src/vc_test_config.svh ====
/*
  Build-time sizing for the stream test subsystem.
  Included by the package and by every module that sizes storage or seeds state.
*/
`ifndef VC_TEST_CONFIG_SVH
`define VC_TEST_CONFIG_SVH

// ----------------------------------------------------------
// Message and table sizing
// ----------------------------------------------------------

// Bits per message
`define VC_MSG_NBITS 8

// Entries in each source/sink table
`define VC_NUM_MSGS 64

// log2 of the table depth
`define VC_IDX_NBITS 6

// ----------------------------------------------------------
// Random delay stage
// ----------------------------------------------------------

// Width of max_delay and of the wait counter
`define VC_DELAY_NBITS 32

// LFSR reset value, must be nonzero
`define VC_LFSR_SEED 16'hACE1

`endif

// ==== src/vc_test_pkg.sv ====
/*
  Shared types for the stream test subsystem.
  Compiled first; modules pull it in with a wildcard import.
*/
`default_nettype none

`include "vc_test_config.svh"

package vc_test_pkg;

  // One stream message
  typedef logic [`VC_MSG_NBITS-1:0] msg_t;

  // Table index or message count
  // One extra bit so a full table count fits
  typedef logic [`VC_IDX_NBITS:0] idx_t;

  // Delay bound and wait counter
  typedef logic [`VC_DELAY_NBITS-1:0] delay_t;

  // Random state of the delay stage
  typedef logic [15:0] lfsr_t;

  // Delay stage FSM
  typedef enum logic [1:0] {
    DLY_IDLE,  // ready for a new message
    DLY_WAIT,  // counting down the drawn delay
    DLY_SEND   // offering the held message downstream
  } delay_state_t;

endpackage

`default_nettype wire

// ==== src/test_source.sv ====
/*
  Table-driven val/rdy producer. The table is written through the load port
  while in reset, then entries 0..num_msgs-1 are played out in order.
*/
`timescale 1ns/100ps
`default_nettype none

`include "vc_test_config.svh"

module test_source
(
  input  logic               clk,
  input  logic               reset,
  input  logic               load_en,
  input  vc_test_pkg::idx_t  load_idx,
  input  vc_test_pkg::msg_t  load_msg,
  input  vc_test_pkg::idx_t  num_msgs,
  input  logic               rdy,
  output logic               val,
  output vc_test_pkg::msg_t  msg,
  output logic               done
);

  import vc_test_pkg::*;

  // ----------------------------------------------------------
  // Message table
  // ----------------------------------------------------------

  msg_t mem [`VC_NUM_MSGS];

  // Table write, one entry per cycle
  always_ff @(posedge clk)
  begin
    if (load_en)
      mem[load_idx[`VC_IDX_NBITS-1:0]] <= load_msg;
  end

  // ----------------------------------------------------------
  // Send side
  // ----------------------------------------------------------

  idx_t send_idx;
  logic running;
  logic xfer;

  // Handshake completes this cycle
  assign xfer = val && rdy;

  // Running goes high in the first cycle out of reset
  // so val stays low while reset is held
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      running  <= 1'b0;
      send_idx <= '0;
    end
    else
    begin
      running <= 1'b1;
      if (xfer)
        send_idx <= send_idx + 1'b1;
    end
  end

  // Offer current entry until the count is reached
  assign val  = running && (send_idx < num_msgs);
  assign msg  = mem[send_idx[`VC_IDX_NBITS-1:0]];

  // All entries handed off
  assign done = (send_idx >= num_msgs);

endmodule

`default_nettype wire

// ==== src/rand_delay.sv ====
/*
  Random-delay val/rdy stage. Holds each message for a pseudo-random
  number of cycles in 0..max_delay before offering it downstream.
*/
`timescale 1ns/100ps
`default_nettype none

`include "vc_test_config.svh"

module rand_delay
(
  input  logic                 clk,
  input  logic                 reset,
  input  vc_test_pkg::delay_t  max_delay,
  input  logic                 in_val,
  input  vc_test_pkg::msg_t    in_msg,
  input  logic                 out_rdy,
  output logic                 in_rdy,
  output logic                 out_val,
  output vc_test_pkg::msg_t    out_msg
);

  import vc_test_pkg::*;

  // ----------------------------------------------------------
  // Pseudo-random source
  // ----------------------------------------------------------

  lfsr_t lfsr;

  // Galois form, taps 16,14,13,11
  always_ff @(posedge clk)
  begin
    if (reset)
      lfsr <= `VC_LFSR_SEED;
    else
      lfsr <= {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
  end

  // Draw in 0..max_delay
  // Bound computed one bit wider so an all-ones max_delay still works
  logic [`VC_DELAY_NBITS:0] bound_ext;
  logic [`VC_DELAY_NBITS:0] lfsr_ext;
  logic [`VC_DELAY_NBITS:0] draw_ext;
  delay_t                   draw;

  assign bound_ext = {1'b0, max_delay} + {{`VC_DELAY_NBITS{1'b0}}, 1'b1};
  assign lfsr_ext  = (`VC_DELAY_NBITS+1)'(lfsr);
  assign draw_ext  = lfsr_ext % bound_ext;
  assign draw      = draw_ext[`VC_DELAY_NBITS-1:0];

  // ----------------------------------------------------------
  // Delay FSM
  // ----------------------------------------------------------

  delay_state_t state;
  delay_t       count;

  // Upstream accepted only when empty
  assign in_rdy  = (state == DLY_IDLE);
  assign out_val = (state == DLY_SEND);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= DLY_IDLE;
      count <= '0;
    end
    else
    begin
      case (state)
        DLY_IDLE:
        begin
          if (in_val)
          begin
            // Zero draw skips the wait entirely
            if (draw == '0)
              state <= DLY_SEND;
            else
              state <= DLY_WAIT;
            count <= draw - 1'b1;
          end
        end
        DLY_WAIT:
        begin
          if (count == '0)
            state <= DLY_SEND;
          else
            count <= count - 1'b1;
        end
        DLY_SEND:
        begin
          if (out_rdy)
            state <= DLY_IDLE;
        end
        default: state <= DLY_IDLE;
      endcase
    end
  end

  // Payload capture on upstream handshake
  always_ff @(posedge clk)
  begin
    if (in_val && in_rdy)
      out_msg <= in_msg;
  end

endmodule

`default_nettype wire

// ==== src/test_rand_delay_source.sv ====
/*
  Table source followed by a random-delay stage, seen from outside as a
  single producer. done waits for the delay stage to drain as well.
*/
`timescale 1ns/100ps
`default_nettype none

module test_rand_delay_source
(
  input  logic                 clk,
  input  logic                 reset,
  input  vc_test_pkg::delay_t  max_delay,
  input  logic                 load_en,
  input  vc_test_pkg::idx_t    load_idx,
  input  vc_test_pkg::msg_t    load_msg,
  input  vc_test_pkg::idx_t    num_msgs,
  input  logic                 rdy,
  output logic                 val,
  output vc_test_pkg::msg_t    msg,
  output logic                 done
);

  import vc_test_pkg::*;

  // Source to delay stage
  logic src_val;
  logic src_rdy;
  msg_t src_msg;
  logic src_done;

  test_source u_src
  (
    .clk      (clk),
    .reset    (reset),
    .load_en  (load_en),
    .load_idx (load_idx),
    .load_msg (load_msg),
    .num_msgs (num_msgs),
    .rdy      (src_rdy),
    .val      (src_val),
    .msg      (src_msg),
    .done     (src_done)
  );

  rand_delay u_delay
  (
    .clk       (clk),
    .reset     (reset),
    .max_delay (max_delay),
    .in_val    (src_val),
    .in_msg    (src_msg),
    .out_rdy   (rdy),
    .in_rdy    (src_rdy),
    .out_val   (val),
    .out_msg   (msg)
  );

  // Delay stage is idle exactly when it is ready upstream
  assign done = src_done && src_rdy;

endmodule

`default_nettype wire

// ==== src/test_sink.sv ====
/*
  Table-driven val/rdy consumer. Checks each arrival against the expected
  table in order and keeps the index of the first mismatch.
*/
`timescale 1ns/100ps
`default_nettype none

`include "vc_test_config.svh"

module test_sink
(
  input  logic               clk,
  input  logic               reset,
  input  logic               load_en,
  input  vc_test_pkg::idx_t  load_idx,
  input  vc_test_pkg::msg_t  load_msg,
  input  vc_test_pkg::idx_t  num_msgs,
  input  logic               val,
  input  vc_test_pkg::msg_t  msg,
  output logic               rdy,
  output logic               done,
  output logic               error,
  output vc_test_pkg::idx_t  err_idx
);

  import vc_test_pkg::*;

  // ----------------------------------------------------------
  // Expected table
  // ----------------------------------------------------------

  msg_t mem [`VC_NUM_MSGS];

  always_ff @(posedge clk)
  begin
    if (load_en)
      mem[load_idx[`VC_IDX_NBITS-1:0]] <= load_msg;
  end

  // ----------------------------------------------------------
  // Receive and compare
  // ----------------------------------------------------------

  idx_t recv_idx;
  idx_t recv_idx_next;
  msg_t expected;
  logic xfer;
  logic mismatch;

  assign xfer          = val && rdy;
  assign expected      = mem[recv_idx[`VC_IDX_NBITS-1:0]];
  assign mismatch      = xfer && (msg != expected);
  assign recv_idx_next = xfer ? recv_idx + 1'b1 : recv_idx;

  // Always ready once out of reset
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rdy      <= 1'b0;
      recv_idx <= '0;
      done     <= 1'b0;
    end
    else
    begin
      rdy      <= 1'b1;
      recv_idx <= recv_idx_next;
      // Counts the transfer of this cycle
      done     <= (recv_idx_next >= num_msgs);
    end
  end

  // First mismatch wins, error is sticky until reset
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      error   <= 1'b0;
      err_idx <= '0;
    end
    else if (mismatch && !error)
    begin
      error   <= 1'b1;
      err_idx <= recv_idx;
    end
  end

endmodule

`default_nettype wire

// ==== src/test_harness.sv ====
/*
  Top level of the stream test subsystem: delayed table source feeding the
  checking sink. done rises once both ends have finished.
*/
`timescale 1ns/100ps
`default_nettype none

module test_harness
(
  input  logic                 clk,
  input  logic                 reset,
  input  vc_test_pkg::delay_t  max_delay,
  input  logic                 src_load_en,
  input  logic                 sink_load_en,
  input  vc_test_pkg::idx_t    load_idx,
  input  vc_test_pkg::msg_t    load_msg,
  input  vc_test_pkg::idx_t    num_msgs,
  output logic                 val,
  output logic                 rdy,
  output vc_test_pkg::msg_t    msg,
  output logic                 done,
  output logic                 error,
  output vc_test_pkg::idx_t    err_idx
);

  // Per-end completion
  logic src_done;
  logic sink_done;

  // ----------------------------------------------------------
  // Producer side
  // ----------------------------------------------------------

  test_rand_delay_source u_src
  (
    .clk       (clk),
    .reset     (reset),
    .max_delay (max_delay),
    .load_en   (src_load_en),
    .load_idx  (load_idx),
    .load_msg  (load_msg),
    .num_msgs  (num_msgs),
    .rdy       (rdy),
    .val       (val),
    .msg       (msg),
    .done      (src_done)
  );

  // ----------------------------------------------------------
  // Consumer side
  // ----------------------------------------------------------

  test_sink u_sink
  (
    .clk      (clk),
    .reset    (reset),
    .load_en  (sink_load_en),
    .load_idx (load_idx),
    .load_msg (load_msg),
    .num_msgs (num_msgs),
    .val      (val),
    .msg      (msg),
    .rdy      (rdy),
    .done     (sink_done),
    .error    (error),
    .err_idx  (err_idx)
  );

  // Sink done is registered, so this is low through reset
  assign done = src_done && sink_done;

endmodule

`default_nettype wire

// ==== verif/tb_test_harness.sv ====
/*
  Self-checking testbench for the stream test harness. Loads random tables,
  sweeps the delay bound and checks both streams with concurrent assertions.
*/
`timescale 1ns/100ps
`default_nettype none

`include "vc_test_config.svh"

module tb_test_harness;

  import vc_test_pkg::*;

  // DUT ports
  logic   clk;
  logic   reset;
  delay_t max_delay;
  logic   src_load_en;
  logic   sink_load_en;
  idx_t   load_idx;
  msg_t   load_msg;
  idx_t   num_msgs;
  logic   val;
  logic   rdy;
  msg_t   msg;
  logic   done;
  logic   error;
  idx_t   err_idx;

  test_harness u_dut
  (
    .clk          (clk),
    .reset        (reset),
    .max_delay    (max_delay),
    .src_load_en  (src_load_en),
    .sink_load_en (sink_load_en),
    .load_idx     (load_idx),
    .load_msg     (load_msg),
    .num_msgs     (num_msgs),
    .val          (val),
    .rdy          (rdy),
    .msg          (msg),
    .done         (done),
    .error        (error),
    .err_idx      (err_idx)
  );

  // 4 ns clock
  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Source to delay stage stream, the only place back-pressure occurs
  logic up_val;
  logic up_rdy;
  msg_t up_msg;

  assign up_val = u_dut.u_src.src_val;
  assign up_rdy = u_dut.u_src.src_rdy;
  assign up_msg = u_dut.u_src.src_msg;

  // ----------------------------------------------------------
  // Reference model and scoreboard
  // ----------------------------------------------------------

  msg_t   src_table [`VC_NUM_MSGS];
  integer seed;
  logic   bad_active;
  idx_t   bad_idx;

  idx_t   sb_idx;
  integer cycles_since;
  logic   seen_xfer;
  integer since_reset;
  logic   xfer;
  msg_t   exp_msg;

  assign xfer    = val && rdy;
  assign exp_msg = src_table[sb_idx[`VC_IDX_NBITS-1:0]];

  // Transfer count, spacing since last transfer, cycles out of reset
  always @(posedge clk)
  begin
    if (reset)
    begin
      sb_idx       <= '0;
      cycles_since <= 0;
      seen_xfer    <= 1'b0;
      since_reset  <= 0;
    end
    else
    begin
      since_reset <= since_reset + 1;
      if (xfer)
      begin
        sb_idx       <= sb_idx + 1'b1;
        cycles_since <= 1;
        seen_xfer    <= 1'b1;
      end
      else
        cycles_since <= cycles_since + 1;
    end
  end

  task automatic stop_on_failure();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic fail_check(input string what);
    $display("CHECK FAILED at %0t ns: %s", $time, what);
    stop_on_failure();
  endtask

  // ----------------------------------------------------------
  // Stream checks
  // ----------------------------------------------------------

  // In-order delivery of the source table
  a_msg_order: assert property (@(posedge clk) disable iff (reset)
    xfer |-> (msg == exp_msg))
    else fail_check("delivered msg differs from source table entry");
  a_xfer_count: assert property (@(posedge clk) disable iff (reset)
    xfer |-> (sb_idx < num_msgs))
    else fail_check("more transfers than num_msgs");
  a_done_count: assert property (@(posedge clk) disable iff (reset)
    done |-> (sb_idx == num_msgs))
    else fail_check("done with transfer count not equal to num_msgs");
  a_done_sticky: assert property (@(posedge clk) disable iff (reset)
    done |=> done)
    else fail_check("done fell before reset");

  // Spacing of consecutive transfers
  a_zero_gap: assert property (@(posedge clk) disable iff (reset)
    (xfer && seen_xfer && max_delay == '0) |-> (cycles_since == 2))
    else fail_check("transfers not two cycles apart with zero delay bound");
  a_gap_bound: assert property (@(posedge clk) disable iff (reset)
    (xfer && seen_xfer) |-> (cycles_since <= max_delay + 2))
    else fail_check("gap between transfers exceeds max_delay+2");

  // Handshake hold rules on the stalled upstream side
  a_hold_msg: assert property (@(posedge clk) disable iff (reset)
    (up_val && !up_rdy) |=> $stable(up_msg))
    else fail_check("source msg changed while stalled");
  a_hold_val: assert property (@(posedge clk) disable iff (reset)
    (up_val && !up_rdy) |=> up_val)
    else fail_check("source val dropped before transfer");

  // Sink always ready once out of reset
  a_rdy_high: assert property (@(posedge clk) disable iff (reset)
    !$past(reset) |-> rdy)
    else fail_check("sink rdy low out of reset");

  // Mismatch capture in the sink
  a_no_error: assert property (@(posedge clk) disable iff (reset)
    !bad_active |-> !error)
    else fail_check("error raised with matching tables");
  a_no_early_error: assert property (@(posedge clk) disable iff (reset)
    (bad_active && sb_idx <= bad_idx) |-> !error)
    else fail_check("error raised before the corrupted entry arrived");
  a_error_capture: assert property (@(posedge clk) disable iff (reset)
    (bad_active && xfer && sb_idx == bad_idx) |=> (error && err_idx == bad_idx))
    else fail_check("error or err_idx wrong after corrupted transfer");
  a_error_sticky: assert property (@(posedge clk) disable iff (reset)
    error |=> error)
    else fail_check("error fell before reset");
  a_error_at_done: assert property (@(posedge clk) disable iff (reset)
    (bad_active && done) |-> (error && err_idx == bad_idx))
    else fail_check("error or err_idx wrong at done");

  // Empty table
  a_empty_no_val: assert property (@(posedge clk) disable iff (reset)
    (num_msgs == '0) |-> !val)
    else fail_check("val raised with num_msgs of zero");
  a_empty_done: assert property (@(posedge clk) disable iff (reset)
    (num_msgs == '0 && since_reset >= 2) |-> done)
    else fail_check("done late with num_msgs of zero");

  // Outputs cleared by reset
  a_reset_values: assert property (@(posedge clk)
    $past(reset) |-> (!val && !done && !error && !rdy))
    else fail_check("val, done, error or rdy high after reset");

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  // Drive point, 1 ns past the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic fill_table();
    idx_t i;
    for (i = '0; i < idx_t'(`VC_NUM_MSGS); i++)
      src_table[i[`VC_IDX_NBITS-1:0]] = msg_t'($random(seed));
  endtask

  // Tables loaded under reset, then 4 more reset cycles
  task automatic start_run(input idx_t n, input delay_t bound, input logic corrupt,
                           input idx_t k);
    idx_t i;
    tick();
    reset = 1'b1;
    tick();
    num_msgs   = n;
    max_delay  = bound;
    bad_active = corrupt;
    bad_idx    = k;
    for (i = '0; i < idx_t'(`VC_NUM_MSGS); i++)
    begin
      load_idx     = i;
      load_msg     = src_table[i[`VC_IDX_NBITS-1:0]];
      src_load_en  = 1'b1;
      sink_load_en = 1'b1;
      tick();
    end
    // Overwrite one sink entry with its inverse
    if (corrupt)
    begin
      src_load_en = 1'b0;
      load_idx    = k;
      load_msg    = ~src_table[k[`VC_IDX_NBITS-1:0]];
      tick();
    end
    src_load_en  = 1'b0;
    sink_load_en = 1'b0;
    repeat (4) tick();
    reset = 1'b0;
  endtask

  task automatic pulse_reset();
    reset = 1'b1;
    repeat (4) tick();
    reset = 1'b0;
  endtask

  task automatic wait_done();
    integer limit;
    integer cycles;
    limit  = int'(num_msgs) * (int'(max_delay) + 2) + 20;
    cycles = 0;
    while (!done && cycles <= limit)
    begin
      tick();
      cycles++;
    end
    if (!done)
    begin
      $display("Timeout: done did not rise within %0d cycles", limit);
      stop_on_failure();
    end
  endtask

  task automatic wait_transfers(input idx_t target);
    integer limit;
    integer cycles;
    limit  = int'(target) * (int'(max_delay) + 2) + 20;
    cycles = 0;
    while (sb_idx < target && cycles <= limit)
    begin
      tick();
      cycles++;
    end
    if (sb_idx < target)
    begin
      $display("Timeout: only %0d of %0d transfers seen", sb_idx, target);
      stop_on_failure();
    end
  endtask

  task automatic run_clean(input delay_t bound);
    start_run(idx_t'(`VC_NUM_MSGS), bound, 1'b0, idx_t'(0));
    wait_done();
    repeat (3) tick();
  endtask

  initial
  begin
    seed         = 88;
    reset        = 1'b1;
    max_delay    = '0;
    src_load_en  = 1'b0;
    sink_load_en = 1'b0;
    load_idx     = '0;
    load_msg     = '0;
    num_msgs     = '0;
    bad_active   = 1'b0;
    bad_idx      = '0;
    fill_table();

    // Delay bound sweep, matching tables
    run_clean(delay_t'(0));
    run_clean(delay_t'(1));
    run_clean(delay_t'(2));
    run_clean(delay_t'(10));

    // One corrupted sink entry
    fill_table();
    start_run(idx_t'(`VC_NUM_MSGS), delay_t'(3), 1'b1, idx_t'(17));
    wait_done();
    repeat (3) tick();

    // Empty table
    start_run(idx_t'(0), delay_t'(5), 1'b0, idx_t'(0));
    wait_done();
    repeat (4) tick();

    // Reset mid-run, then a full replay
    fill_table();
    start_run(idx_t'(`VC_NUM_MSGS), delay_t'(2), 1'b0, idx_t'(0));
    wait_transfers(idx_t'(20));
    pulse_reset();
    wait_done();
    repeat (3) tick();

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/vc_test_pkg.sv
src/test_source.sv
src/rand_delay.sv
src/test_rand_delay_source.sv
src/test_sink.sv
src/test_harness.sv
verif/tb_test_harness.sv

// ==== Makefile ====
# Verilator build and run of the stream test harness testbench

TOP := tb_test_harness
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
